/* Bender.yml */
package:
  name: cpu_pipe

# in-order 16-bit core: decode, execute with bypass, writeback

sources:
  # RTL, package first
  - files:
      - source/cpu_pkg.sv
      - source/pipe_decode.sv
      - source/pipe_execute.sv
      - source/pipe_writeback.sv
      - source/cpu_top.sv

  # testbench and bound checker
  - target: test
    files:
      - testbench/cpu_assert.sv
      - testbench/cpu_tb.sv

/* all.f */
source/cpu_pkg.sv
source/pipe_decode.sv
source/pipe_execute.sv
source/pipe_writeback.sv
source/cpu_top.sv
testbench/cpu_assert.sv
testbench/cpu_tb.sv

/* source/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

	// machine widths fixed by the instruction format
	localparam int WORD_W    = 16;
	localparam int REG_IDX_W = 2;
	localparam int NUM_REGS  = 4;
	localparam int OPCODE_W  = 4;
	localparam int FUNC_W    = 6;
	localparam int IMM_W     = 8;

	// instruction field positions
	localparam int OPCODE_LSB = 12;
	localparam int RS_LSB     = 10;
	localparam int RT_LSB     = 8;
	localparam int RD_LSB     = 6;

	typedef logic [WORD_W-1:0]    word_t;
	typedef logic [REG_IDX_W-1:0] reg_idx_t;

	// top field of the instruction
	typedef enum logic [OPCODE_W-1:0] {
		OP_ADI   = 4'd4,
		OP_ORI   = 4'd5,
		OP_LHI   = 4'd6,
		OP_RTYPE = 4'd15
	} opcode_e;

	// function field of r-type instructions
	typedef enum logic [FUNC_W-1:0] {
		FN_ADD = 6'd0,
		FN_SUB = 6'd1,
		FN_AND = 6'd2,
		FN_ORR = 6'd3,
		FN_NOT = 6'd4,
		FN_TCP = 6'd5,
		FN_SHL = 6'd6,
		FN_SHR = 6'd7,
		FN_WWD = 6'd28,
		FN_HLT = 6'd29
	} func_e;

	// operation carried out in the execute stage
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_NOT,
		ALU_NEG,
		ALU_SHL,
		ALU_SHR,
		ALU_PASS_IMM,
		ALU_PASS_A,
		ALU_NOP
	} alu_op_e;

	// decode to execute
	typedef struct packed {
		logic     valid;
		alu_op_e  op;
		reg_idx_t rs;
		reg_idx_t rt;
		reg_idx_t dst;
		word_t    imm;
		// second operand comes from imm instead of rt
		logic     use_imm;
		logic     writes;
		logic     wwd;
		logic     halt;
	} decoded_t;

	// execute to writeback and also the bypass source
	typedef struct packed {
		logic     valid;
		logic     write;
		reg_idx_t dst;
		word_t    value;
		logic     wwd;
		logic     halt;
	} result_t;

endpackage

`default_nettype wire

/* source/cpu_top.sv */
`default_nettype none

module cpu_top (
	input  logic           clk,
	input  logic           reset_n,
	input  logic           instr_valid,
	input  cpu_pkg::word_t instr,
	output cpu_pkg::word_t output_port,
	output cpu_pkg::word_t num_inst,
	output logic           is_halted
);
	import cpu_pkg::*;

	decoded_t dec;
	result_t  res;
	reg_idx_t rf_a_idx;
	reg_idx_t rf_b_idx;
	word_t    rf_a;
	word_t    rf_b;

	pipe_decode u_decode (
		.clk         (clk),
		.reset_n     (reset_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.dec         (dec)
	);

	pipe_execute u_execute (
		.clk      (clk),
		.reset_n  (reset_n),
		.dec      (dec),
		.rf_a_idx (rf_a_idx),
		.rf_b_idx (rf_b_idx),
		.rf_a     (rf_a),
		.rf_b     (rf_b),
		.res      (res)
	);

	pipe_writeback u_writeback (
		.clk         (clk),
		.reset_n     (reset_n),
		.rf_a_idx    (rf_a_idx),
		.rf_b_idx    (rf_b_idx),
		.rf_a        (rf_a),
		.rf_b        (rf_b),
		.res         (res),
		.output_port (output_port),
		.num_inst    (num_inst),
		.is_halted   (is_halted)
	);

endmodule

`default_nettype wire

/* source/pipe_decode.sv */
`default_nettype none

module pipe_decode (
	input  logic             clk,
	input  logic             reset_n,
	input  logic             instr_valid,
	input  cpu_pkg::word_t   instr,
	output cpu_pkg::decoded_t dec
);
	import cpu_pkg::*;

	opcode_e            opcode;
	func_e              func;
	logic [IMM_W-1:0]   imm8;
	logic               halt_seen;
	logic               accept;
	decoded_t           dec_next;

	assign opcode = opcode_e'(instr[OPCODE_LSB +: OPCODE_W]);
	assign func   = func_e'(instr[FUNC_W-1:0]);
	assign imm8   = instr[IMM_W-1:0];

	// nothing gets in once HLT has been taken
	assign accept = instr_valid && !halt_seen;

	always_comb begin
		dec_next         = '0;
		dec_next.valid   = accept;
		dec_next.op      = ALU_NOP;
		dec_next.rs      = instr[RS_LSB +: REG_IDX_W];
		dec_next.rt      = instr[RT_LSB +: REG_IDX_W];
		dec_next.dst     = instr[RT_LSB +: REG_IDX_W];
		case (opcode)
			OP_ADI: begin
				dec_next.op      = ALU_ADD;
				dec_next.imm     = {{(WORD_W - IMM_W){imm8[IMM_W-1]}}, imm8};
				dec_next.use_imm = 1'b1;
				dec_next.writes  = 1'b1;
			end
			OP_ORI: begin
				dec_next.op      = ALU_OR;
				dec_next.imm     = {{(WORD_W - IMM_W){1'b0}}, imm8};
				dec_next.use_imm = 1'b1;
				dec_next.writes  = 1'b1;
			end
			OP_LHI: begin
				dec_next.op     = ALU_PASS_IMM;
				dec_next.imm    = {imm8, {(WORD_W - IMM_W){1'b0}}};
				dec_next.writes = 1'b1;
			end
			OP_RTYPE: begin
				// r-type writes to rd
				dec_next.dst    = instr[RD_LSB +: REG_IDX_W];
				dec_next.writes = 1'b1;
				case (func)
					FN_ADD: dec_next.op = ALU_ADD;
					FN_SUB: dec_next.op = ALU_SUB;
					FN_AND: dec_next.op = ALU_AND;
					FN_ORR: dec_next.op = ALU_OR;
					FN_NOT: dec_next.op = ALU_NOT;
					FN_TCP: dec_next.op = ALU_NEG;
					FN_SHL: dec_next.op = ALU_SHL;
					FN_SHR: dec_next.op = ALU_SHR;
					FN_WWD: begin
						dec_next.op     = ALU_PASS_A;
						dec_next.wwd    = 1'b1;
						dec_next.writes = 1'b0;
					end
					FN_HLT: begin
						dec_next.halt   = 1'b1;
						dec_next.writes = 1'b0;
					end
					default: dec_next.writes = 1'b0;
				endcase
			end
			// unknown opcode retires as a no-op
			default: dec_next.op = ALU_NOP;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			dec       <= '0;
			halt_seen <= 1'b0;
		end else begin
			dec <= dec_next;
			if (accept && dec_next.halt) begin
				halt_seen <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* source/pipe_execute.sv */
`default_nettype none

module pipe_execute (
	input  logic              clk,
	input  logic              reset_n,
	input  cpu_pkg::decoded_t dec,
	output cpu_pkg::reg_idx_t rf_a_idx,
	output cpu_pkg::reg_idx_t rf_b_idx,
	input  cpu_pkg::word_t    rf_a,
	input  cpu_pkg::word_t    rf_b,
	output cpu_pkg::result_t  res
);
	import cpu_pkg::*;

	logic  hit_a;
	logic  hit_b;
	word_t op_a;
	word_t reg_b;
	word_t op_b;
	word_t alu_out;

	// register file is read straight from the decode register
	assign rf_a_idx = dec.rs;
	assign rf_b_idx = dec.rt;

	// the instruction just ahead sits in res and is not yet written back
	assign hit_a = res.valid && res.write && (res.dst == dec.rs);
	assign hit_b = res.valid && res.write && (res.dst == dec.rt);

	assign op_a  = hit_a ? res.value : rf_a;
	assign reg_b = hit_b ? res.value : rf_b;
	assign op_b  = dec.use_imm ? dec.imm : reg_b;

	always_comb begin
		case (dec.op)
			ALU_ADD:      alu_out = op_a + op_b;
			ALU_SUB:      alu_out = op_a - op_b;
			ALU_AND:      alu_out = op_a & op_b;
			ALU_OR:       alu_out = op_a | op_b;
			ALU_NOT:      alu_out = ~op_a;
			ALU_NEG:      alu_out = ~op_a + word_t'(1);
			ALU_SHL:      alu_out = {op_a[WORD_W-2:0], 1'b0};
			// arithmetic with the sign bit kept
			ALU_SHR:      alu_out = {op_a[WORD_W-1], op_a[WORD_W-1:1]};
			ALU_PASS_IMM: alu_out = dec.imm;
			ALU_PASS_A:   alu_out = op_a;
			default:      alu_out = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			res <= '0;
		end else begin
			res.valid <= dec.valid;
			res.write <= dec.valid && dec.writes;
			res.dst   <= dec.dst;
			res.value <= alu_out;
			res.wwd   <= dec.valid && dec.wwd;
			res.halt  <= dec.valid && dec.halt;
		end
	end

endmodule

`default_nettype wire

/* source/pipe_writeback.sv */
`default_nettype none

module pipe_writeback (
	input  logic              clk,
	input  logic              reset_n,
	input  cpu_pkg::reg_idx_t rf_a_idx,
	input  cpu_pkg::reg_idx_t rf_b_idx,
	output cpu_pkg::word_t    rf_a,
	output cpu_pkg::word_t    rf_b,
	input  cpu_pkg::result_t  res,
	output cpu_pkg::word_t    output_port,
	output cpu_pkg::word_t    num_inst,
	output logic              is_halted
);
	import cpu_pkg::*;

	word_t rf [NUM_REGS];

	// read ports are combinational and the write lands at the clock edge
	assign rf_a = rf[rf_a_idx];
	assign rf_b = rf[rf_b_idx];

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				rf[i] <= '0;
			end
		end else if (res.valid && res.write) begin
			rf[res.dst] <= res.value;
		end
	end

	// retire side with output port, count and halt
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			output_port <= '0;
			num_inst    <= '0;
			is_halted   <= 1'b0;
		end else if (res.valid) begin
			// no-ops count as well
			num_inst <= num_inst + word_t'(1);
			if (res.wwd) begin
				output_port <= res.value;
			end
			if (res.halt) begin
				is_halted <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* testbench/cpu_assert.sv */
`default_nettype none

module cpu_assert (
	input logic           clk,
	input logic           reset_n,
	input cpu_pkg::word_t output_port,
	input cpu_pkg::word_t num_inst,
	input logic           is_halted
);
	timeunit 1ns;
	timeprecision 1ps;

	import cpu_pkg::*;

	// at most one instruction retires per cycle
	count_step: assert property (@(posedge clk) disable iff (!reset_n)
		(num_inst == $past(num_inst)) || (num_inst == $past(num_inst) + word_t'(1)))
		else $error("num_inst changed by more than one in a cycle");

	// halt is sticky until reset
	halt_sticky: assert property (@(posedge clk) disable iff (!reset_n)
		!$fell(is_halted))
		else $error("is_halted fell without a reset");

	reset_clear: assert property (@(posedge clk)
		!reset_n |=> (output_port == '0) && (num_inst == '0) && !is_halted)
		else $error("outputs not cleared in the cycle after reset");

endmodule

bind cpu_top cpu_assert u_assert (
	.clk         (clk),
	.reset_n     (reset_n),
	.output_port (output_port),
	.num_inst    (num_inst),
	.is_halted   (is_halted)
);

`default_nettype wire

/* testbench/cpu_tb.sv */
`default_nettype none

module cpu_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import cpu_pkg::*;

	localparam int NUM_INSTR   = 400;
	localparam int NUM_AFTER   = 6;
	localparam int DRAIN_LIMIT = 50;

	// port values the DUT must show three falling edges after the drive
	typedef struct packed {
		word_t out;
		word_t cnt;
		logic  halt;
	} port_state_t;

	logic  clk;
	logic  reset_n;
	logic  instr_valid;
	word_t instr;
	word_t output_port;
	word_t num_inst;
	logic  is_halted;

	// reference model
	word_t       m_regs [NUM_REGS];
	port_state_t m_state;
	logic        m_halt_seen;
	port_state_t exp_q [$];

	int error_count;
	int check_count;
	int seed_val;

	cpu_top u_dut (
		.clk         (clk),
		.reset_n     (reset_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.output_port (output_port),
		.num_inst    (num_inst),
		.is_halted   (is_halted)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#5 clk = ~clk;
		end
	end

	task automatic check_word(input string name, input word_t got, input word_t exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("FAILED %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("FAILED %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic init_model();
		for (int i = 0; i < NUM_REGS; i++) begin
			m_regs[i] = '0;
		end
		m_state     = '0;
		m_halt_seen = 1'b0;
	endtask

	// one accepted instruction from the instruction semantics
	task automatic apply_model(input word_t ins);
		logic [3:0] opc;
		logic [5:0] fn;
		logic [1:0] rs;
		logic [1:0] rt;
		logic [1:0] rd;
		logic [7:0] imm8;
		word_t      a;
		word_t      b;
		opc  = ins[15:12];
		rs   = ins[11:10];
		rt   = ins[9:8];
		rd   = ins[7:6];
		fn   = ins[5:0];
		imm8 = ins[7:0];
		a    = m_regs[rs];
		b    = m_regs[rt];
		m_state.cnt = m_state.cnt + 16'd1;
		case (opc)
			OP_ADI: m_regs[rt] = a + {{8{imm8[7]}}, imm8};
			OP_ORI: m_regs[rt] = a | {8'h00, imm8};
			OP_LHI: m_regs[rt] = {imm8, 8'h00};
			OP_RTYPE: begin
				case (fn)
					FN_ADD: m_regs[rd] = a + b;
					FN_SUB: m_regs[rd] = a - b;
					FN_AND: m_regs[rd] = a & b;
					FN_ORR: m_regs[rd] = a | b;
					FN_NOT: m_regs[rd] = ~a;
					FN_TCP: m_regs[rd] = 16'd0 - a;
					FN_SHL: m_regs[rd] = a << 1;
					FN_SHR: m_regs[rd] = $signed(a) >>> 1;
					FN_WWD: m_state.out = a;
					FN_HLT: begin
						m_state.halt = 1'b1;
						m_halt_seen  = 1'b1;
					end
					default: ;
				endcase
			end
			default: ;
		endcase
	endtask

	// about a quarter WWD and a few no-ops among the ALU work
	function automatic word_t rand_instr();
		int         kind;
		logic [1:0] rs;
		logic [1:0] rt;
		logic [1:0] rd;
		logic [7:0] imm8;
		word_t      ins;
		kind = $urandom_range(0, 15);
		rs   = 2'($urandom_range(0, 3));
		rt   = 2'($urandom_range(0, 3));
		rd   = 2'($urandom_range(0, 3));
		imm8 = 8'($urandom);
		if (kind < 4) begin
			ins = {OP_RTYPE, rs, rt, rd, FN_WWD};
		end else if (kind < 6) begin
			ins = {OP_ADI, rs, rt, imm8};
		end else if (kind == 6) begin
			ins = {OP_ORI, rs, rt, imm8};
		end else if (kind == 7) begin
			ins = {OP_LHI, rs, rt, imm8};
		end else if (kind < 14) begin
			ins = {OP_RTYPE, rs, rt, rd, 6'($urandom_range(0, 7))};
		end else if (kind == 14) begin
			// unused opcode
			ins = {4'($urandom_range(0, 3)), rs, rt, imm8};
		end else begin
			// unused r-type function
			ins = {OP_RTYPE, rs, rt, rd, 6'd12};
		end
		return ins;
	endfunction

	// checks what is due this clock and drives the next input
	task automatic step(input logic valid, input word_t ins);
		port_state_t due;
		@(negedge clk);
		due = exp_q.pop_front();
		check_word("output_port", output_port, due.out);
		check_word("num_inst", num_inst, due.cnt);
		check_flag("is_halted", is_halted, due.halt);
		instr_valid = valid;
		instr       = ins;
		if (valid && !m_halt_seen) begin
			apply_model(ins);
		end
		exp_q.push_back(m_state);
	endtask

	initial begin
		int   gap;
		int   waits;
		logic drained;
		logic timed_out;
		seed_val    = $urandom(57248);
		error_count = 0;
		check_count = 0;
		reset_n     = 1'b0;
		instr_valid = 1'b0;
		instr       = '0;
		init_model();
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset_n = 1'b1;

		check_word("output_port", output_port, '0);
		check_word("num_inst", num_inst, '0);
		check_flag("is_halted", is_halted, 1'b0);
		repeat (3) exp_q.push_back(m_state);

		// gaps of zero keep dependent instructions back to back
		for (int i = 0; i < NUM_INSTR; i++) begin
			gap = ($urandom_range(0, 1) == 0) ? 0 : $urandom_range(1, 3);
			repeat (gap) step(1'b0, word_t'($urandom));
			step(1'b1, rand_instr());
		end
		step(1'b1, {OP_RTYPE, 6'd0, FN_HLT});

		// strobes after HLT must be dropped
		for (int i = 0; i < NUM_AFTER; i++) begin
			repeat ($urandom_range(0, 2)) step(1'b0, word_t'($urandom));
			step(1'b1, rand_instr());
		end

		waits     = 0;
		drained   = 1'b0;
		timed_out = 1'b0;
		while (!drained && !timed_out) begin
			step(1'b0, '0);
			waits++;
			if (is_halted && waits >= 3) begin
				drained = 1'b1;
			end else if (waits >= DRAIN_LIMIT) begin
				timed_out = 1'b1;
			end
		end

		if (timed_out) begin
			$display("timeout: is_halted did not rise within %0d cycles", DRAIN_LIMIT);
		end else begin
			check_word("num_inst", num_inst, word_t'(NUM_INSTR + 1));
		end

		$display("checks: %0d, errors: %0d, timeouts: %0d", check_count, error_count,
			timed_out ? 1 : 0);
		if (timed_out || error_count != 0) begin
			$display("*** FAILED ***");
		end else begin
			$display("*** PASSED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire
